// ==== xmac_settings.svh ====
// Matrix slice sizing
`ifndef XMAC_SETTINGS_SVH
`define XMAC_SETTINGS_SVH

// bits per operand word.
`define XMAC_WORD 16

// words per buffer entry and dot-product lanes.
`define XMAC_WIDTH 4

// slots per row, power of two.
`define XMAC_HEIGHT 4

// output rows and mac_row instances, power of two.
`define XMAC_ROWS 4

// accumulator width.
`define XMAC_ACC 40

`endif

// ==== xmac_pkg.sv ====
// Matrix slice types
`include "xmac_settings.svh"

package xmac_pkg;

  typedef logic signed [`XMAC_WORD-1:0] word_t;
  typedef logic signed [`XMAC_ACC-1:0]  acc_t;

  typedef logic [$clog2(`XMAC_ROWS)-1:0]   row_idx_t;
  typedef logic [$clog2(`XMAC_HEIGHT)-1:0] slot_idx_t;

  // slot in the upper bits, row in the lower bits.
  typedef logic [$clog2(`XMAC_HEIGHT)+$clog2(`XMAC_ROWS)-1:0] buf_addr_t;

  typedef enum logic [1:0] {
    FEED_IDLE,
    FEED_RUN,
    FEED_LAST
  } feed_state_e;

  typedef enum logic {
    DRAIN_IDLE,
    DRAIN_OUT
  } drain_state_e;

endpackage

// ==== x_buffer.sv ====
// X operand buffer
`timescale 1ns/10ps
`include "xmac_settings.svh"

module x_buffer #(
  parameter int unsigned WORD_SIZE = `XMAC_WORD,
  parameter int unsigned WIDTH     = `XMAC_WIDTH,
  parameter int unsigned HEIGHT    = `XMAC_HEIGHT,
  parameter int unsigned N_OUTPUTS = `XMAC_ROWS
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           clear_i,
  input  logic                                           write_en_i,
  input  xmac_pkg::buf_addr_t                            write_addr_i,
  input  logic [WIDTH-1:0][WORD_SIZE-1:0]                wdata_i,
  input  logic                                           read_en_i,
  input  xmac_pkg::buf_addr_t                            read_addr_i,
  output logic [N_OUTPUTS-1:0][WIDTH-1:0][WORD_SIZE-1:0] rdata_o
);
  import xmac_pkg::*;

  localparam int unsigned RW = $clog2(N_OUTPUTS);

  logic [HEIGHT-1:0][N_OUTPUTS-1:0][WIDTH-1:0][WORD_SIZE-1:0] buffer_q;
  slot_idx_t [N_OUTPUTS-1:0]                                  rptr_q;

  row_idx_t  row_w;
  slot_idx_t slot_w;
  row_idx_t  row_r;
  slot_idx_t slot_r;

  assign row_w  = write_addr_i[RW-1:0];
  assign slot_w = write_addr_i[$bits(buf_addr_t)-1:RW];
  assign row_r  = read_addr_i[RW-1:0];
  assign slot_r = read_addr_i[$bits(buf_addr_t)-1:RW];

  // flop storage, one entry per slot and row.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buffer_q <= '0;
    end else if (clear_i) begin
      buffer_q <= '0;
    end else if (write_en_i) begin
      buffer_q[slot_w][row_w] <= wdata_i;
    end
  end

  for (genvar o = 0; o < N_OUTPUTS; o++) begin : gen_rows
    // pointer moves only when a read names this row.
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rptr_q[o] <= '0;
      end else if (clear_i) begin
        rptr_q[o] <= '0;
      end else if (read_en_i && row_r == row_idx_t'(o)) begin
        rptr_q[o] <= slot_r;
      end
    end

    assign rdata_o[o] = buffer_q[rptr_q[o]][o]; // entry at the row's pointer.
  end

endmodule

// ==== x_loader.sv ====
// X load address generator
`timescale 1ns/10ps

module x_loader (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                load_i,
  input  logic                busy_i,
  output logic                write_en_o,
  output xmac_pkg::buf_addr_t write_addr_o
);
  import xmac_pkg::*;

  buf_addr_t addr_q;

  // loads during compute are dropped.
  assign write_en_o   = load_i && !busy_i;
  assign write_addr_o = addr_q;

  // row bits sit low, so a plain count steps the row first.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (clear_i) begin
      addr_q <= '0;
    end else if (write_en_o) begin
      addr_q <= addr_q + 1'b1; // wraps after a full buffer.
    end
  end

endmodule

// ==== x_feeder.sv ====
// Compute sequencer
`timescale 1ns/10ps
`include "xmac_settings.svh"

module x_feeder (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  output logic                   read_en_o,
  output xmac_pkg::buf_addr_t    read_addr_o,
  output logic                   acc_clr_o,
  output logic [`XMAC_ROWS-1:0]  mac_en_o,
  output logic                   capture_o,
  output logic                   busy_o
);
  import xmac_pkg::*;

  localparam int unsigned RW = $clog2(`XMAC_ROWS);

  feed_state_e          state_q;
  buf_addr_t            cnt_q;
  logic                 read_en_q;
  buf_addr_t            read_addr_q;
  logic                 acc_clr_q;
  logic                 capture_q;
  logic [`XMAC_ROWS-1:0] mac_en_q;
  row_idx_t             read_row;

  assign read_row = read_addr_q[RW-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FEED_IDLE;
      cnt_q       <= '0;
      read_en_q   <= 1'b0;
      read_addr_q <= '0;
      acc_clr_q   <= 1'b0;
      capture_q   <= 1'b0;
    end else if (clear_i) begin
      state_q     <= FEED_IDLE;
      cnt_q       <= '0;
      read_en_q   <= 1'b0;
      read_addr_q <= '0;
      acc_clr_q   <= 1'b0;
      capture_q   <= 1'b0;
    end else begin
      read_en_q <= 1'b0;
      acc_clr_q <= 1'b0;
      capture_q <= 1'b0;
      case (state_q)
        FEED_IDLE: begin
          if (start_i) begin
            state_q <= FEED_RUN;
            cnt_q   <= '0;
          end
        end
        FEED_RUN: begin
          read_en_q   <= 1'b1;
          read_addr_q <= cnt_q;
          acc_clr_q   <= (cnt_q == '0); // clear goes out with the first read.
          cnt_q       <= cnt_q + 1'b1;
          if (cnt_q == '1) begin
            state_q <= FEED_LAST;
          end
        end
        FEED_LAST: begin
          // wait out the final enable, then hand over.
          if (!read_en_q) begin
            capture_q <= 1'b1;
            state_q   <= FEED_IDLE;
          end
        end
        default: state_q <= FEED_IDLE;
      endcase
    end
  end

  // enable trails the read by one cycle.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mac_en_q <= '0;
    end else if (clear_i) begin
      mac_en_q <= '0;
    end else if (read_en_q) begin
      mac_en_q <= `XMAC_ROWS'(1) << read_row;
    end else begin
      mac_en_q <= '0;
    end
  end

  assign read_en_o   = read_en_q;
  assign read_addr_o = read_addr_q;
  assign acc_clr_o   = acc_clr_q;
  assign mac_en_o    = mac_en_q;
  assign capture_o   = capture_q;
  assign busy_o      = (state_q != FEED_IDLE);

endmodule

// ==== mac_row.sv ====
// Dot product accumulator
`timescale 1ns/10ps
`include "xmac_settings.svh"

module mac_row (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   clear_i,
  input  logic                                   acc_clr_i,
  input  logic                                   en_i,
  input  xmac_pkg::word_t [`XMAC_WIDTH-1:0]      x_i,
  input  xmac_pkg::word_t [`XMAC_WIDTH-1:0]      w_i,
  output xmac_pkg::acc_t                         acc_o
);
  import xmac_pkg::*;

  localparam int unsigned LANES  = `XMAC_WIDTH;
  localparam int unsigned LEVELS = (LANES > 1) ? $clog2(LANES) : 1;

  logic signed [2*`XMAC_WORD-1:0] prod [LANES];
  acc_t                           sum;
  acc_t                           acc_q;

  for (genvar l = 0; l < LANES; l++) begin : gen_lanes
    assign prod[l] = x_i[l] * w_i[l]; // signed lane product.
  end

  // pairwise adder tree, reduced in place.
  always_comb begin
    acc_t tree [LANES];
    int   n;
    n = LANES;
    for (int l = 0; l < LANES; l++) begin
      tree[l] = prod[l];
    end
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      for (int i = 0; i < LANES; i++) begin
        if (2 * i + 1 < n) begin
          tree[i] = tree[2*i] + tree[2*i+1];
        end else if (2 * i < n) begin
          tree[i] = tree[2*i];
        end
      end
      n = (n + 1) / 2;
    end
    sum = tree[0];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i || acc_clr_i) begin
      acc_q <= '0;
    end else if (en_i) begin
      acc_q <= acc_q + sum; // wraps modulo 2**ACC.
    end
  end

  assign acc_o = acc_q;

endmodule

// ==== result_drain.sv ====
// Serial result drain
`timescale 1ns/10ps
`include "xmac_settings.svh"

module result_drain (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 clear_i,
  input  logic                                 capture_i,
  input  xmac_pkg::acc_t [`XMAC_ROWS-1:0]      acc_i,
  output logic                                 res_valid_o,
  output xmac_pkg::row_idx_t                   res_row_o,
  output xmac_pkg::acc_t                       res_data_o,
  output logic                                 done_o
);
  import xmac_pkg::*;

  localparam row_idx_t LAST_ROW = row_idx_t'(`XMAC_ROWS - 1);

  drain_state_e          state_q;
  row_idx_t              idx_q;
  acc_t [`XMAC_ROWS-1:0] hold_q;

  // snapshot frees the accumulators for the next pass.
  always_ff @(posedge clk_i) begin
    if (capture_i) begin
      hold_q <= acc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DRAIN_IDLE;
      idx_q   <= '0;
    end else if (clear_i) begin
      state_q <= DRAIN_IDLE;
      idx_q   <= '0;
    end else if (capture_i) begin
      state_q <= DRAIN_OUT;
      idx_q   <= '0;
    end else if (state_q == DRAIN_OUT) begin
      idx_q <= idx_q + 1'b1;
      if (idx_q == LAST_ROW) begin
        state_q <= DRAIN_IDLE;
        idx_q   <= '0;
      end
    end
  end

  assign res_valid_o = (state_q == DRAIN_OUT);
  assign res_row_o   = idx_q;
  assign res_data_o  = hold_q[idx_q];
  assign done_o      = res_valid_o && (idx_q == LAST_ROW); // with the last row.

endmodule

// ==== xmac_top.sv ====
// Operand buffer and multiply slice
`timescale 1ns/10ps
`include "xmac_settings.svh"

module xmac_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               clear_i,
  input  logic                               load_i,
  input  xmac_pkg::word_t [`XMAC_WIDTH-1:0]  load_data_i,
  input  xmac_pkg::word_t [`XMAC_WIDTH-1:0]  w_i,
  input  logic                               start_i,
  output logic                               busy_o,
  output logic                               res_valid_o,
  output xmac_pkg::row_idx_t                 res_row_o,
  output xmac_pkg::acc_t                     res_data_o,
  output logic                               done_o
);
  import xmac_pkg::*;

  logic                                  write_en;
  buf_addr_t                             write_addr;
  logic                                  read_en;
  buf_addr_t                             read_addr;
  logic                                  acc_clr;
  logic [`XMAC_ROWS-1:0]                 mac_en;
  logic                                  capture;
  logic                                  busy;
  word_t [`XMAC_ROWS-1:0][`XMAC_WIDTH-1:0] x_rows;
  acc_t [`XMAC_ROWS-1:0]                 acc;

  x_loader u_loader (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .load_i       (load_i),
    .busy_i       (busy),
    .write_en_o   (write_en),
    .write_addr_o (write_addr)
  );

  x_feeder u_feeder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .start_i     (start_i),
    .read_en_o   (read_en),
    .read_addr_o (read_addr),
    .acc_clr_o   (acc_clr),
    .mac_en_o    (mac_en),
    .capture_o   (capture),
    .busy_o      (busy)
  );

  x_buffer u_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .write_en_i   (write_en),
    .write_addr_i (write_addr),
    .wdata_i      (load_data_i),
    .read_en_i    (read_en),
    .read_addr_i  (read_addr),
    .rdata_o      (x_rows)
  );

  for (genvar g = 0; g < `XMAC_ROWS; g++) begin : gen_mac
    mac_row u_mac (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .clear_i   (clear_i),
      .acc_clr_i (acc_clr),
      .en_i      (mac_en[g]),
      .x_i       (x_rows[g]),
      .w_i       (w_i),
      .acc_o     (acc[g])
    );
  end

  result_drain u_drain (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .capture_i   (capture),
    .acc_i       (acc),
    .res_valid_o (res_valid_o),
    .res_row_o   (res_row_o),
    .res_data_o  (res_data_o),
    .done_o      (done_o)
  );

  assign busy_o = busy;

endmodule

// ==== xmac_chk.sv ====
// Result protocol assertions
`timescale 1ns/10ps

module xmac_chk (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               start_i,
  input logic               busy_o,
  input logic               res_valid_o,
  input xmac_pkg::row_idx_t res_row_o,
  input logic               done_o
);
  import xmac_pkg::*;

  int unsigned fail_count = 0; // summed into the testbench error count.

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !res_valid_o && !done_o)
    else begin
      fail_count++;
      $error("result strobe or done active during reset");
    end

  done_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> res_valid_o)
    else begin
      fail_count++;
      $error("done_o high without res_valid_o");
    end

  // rows come out in order.
  row_steps: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && $past(res_valid_o) |-> res_row_o == $past(res_row_o) + row_idx_t'(1))
    else begin
      fail_count++;
      $error("res_row_o did not step between strobes");
    end

  busy_from_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(busy_o) |-> $past(start_i))
    else begin
      fail_count++;
      $error("busy_o rose with no start_i");
    end

endmodule

// ==== tb_xmac.sv ====
// Matrix slice testbench
`timescale 1ns/10ps
`include "xmac_settings.svh"

module tb_xmac;
  import xmac_pkg::*;

  localparam int WIDTH   = `XMAC_WIDTH;
  localparam int ROWS    = `XMAC_ROWS;
  localparam int ENTRIES = `XMAC_HEIGHT * `XMAC_ROWS;
  localparam int LATENCY = ENTRIES + 3;
  localparam int TIMEOUT = 4 * LATENCY;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              clear_i;
  logic              load_i;
  logic              start_i;
  word_t [WIDTH-1:0] load_data_i;
  word_t [WIDTH-1:0] w_i;
  logic              busy_o;
  logic              res_valid_o;
  row_idx_t          res_row_o;
  acc_t              res_data_o;
  logic              done_o;

  word_t  x_model [ENTRIES][WIDTH]; // loaded X by buffer address.
  acc_t   exp_res [ROWS];
  integer seed = 32'h142f6e5a;
  int     load_ptr;
  int     errors;
  int     checks;
  int     cycle_cnt;
  int     start_edge;
  int     row_cnt;
  int     bursts;
  logic   burst_pending = 1'b0;
  logic   in_burst = 1'b0;

  xmac_top dut (.*);

  bind xmac_top xmac_chk u_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .res_valid_o (res_valid_o),
    .res_row_o   (res_row_o),
    .done_o      (done_o)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // x times w summed over slots and lanes and wrapped to the accumulator.
  function automatic acc_t expected_row(input int row, input word_t [WIDTH-1:0] w);
    longint sum;
    sum = 0;
    for (int s = 0; s < `XMAC_HEIGHT; s++) begin
      for (int l = 0; l < WIDTH; l++) begin
        sum += longint'($signed(x_model[s*ROWS+row][l])) * longint'($signed(w[l]));
      end
    end
    return acc_t'(sum);
  endfunction

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (!rst_ni) begin
      row_cnt  = 0;
      in_burst = 1'b0;
    end else begin
      if (start_i && !busy_o && !clear_i) begin
        start_edge = cycle_cnt; // edge that samples start.
      end
      if (res_valid_o) begin
        if (!in_burst) begin
          check_value(64'(burst_pending), 64'(1), "result burst without a compute");
          // strobe is seen one edge after it rises.
          check_value(64'(cycle_cnt - start_edge), 64'(LATENCY + 1), "start to result");
        end
        check_value(64'(res_row_o), 64'(row_cnt), "res_row_o");
        check_value(64'(res_data_o), 64'(exp_res[row_cnt]), "res_data_o");
        check_value(64'(done_o), 64'(row_cnt == ROWS - 1), "done_o");
        in_burst = 1'b1;
        row_cnt++;
        if (row_cnt == ROWS) begin
          row_cnt       = 0;
          in_burst      = 1'b0;
          burst_pending = 1'b0;
          bursts++;
        end
      end else begin
        check_value(64'(in_burst), 64'(0), "gap inside a result burst");
        check_value(64'(done_o), 64'(0), "done_o without res_valid_o");
        in_burst = 1'b0;
        row_cnt  = 0;
      end
    end
  end

  task automatic clear_model();
    for (int e = 0; e < ENTRIES; e++) begin
      for (int l = 0; l < WIDTH; l++) begin
        x_model[e][l] = '0;
      end
    end
    load_ptr = 0;
  endtask

  task automatic clear_buffer();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    clear_model();
  endtask

  task automatic load_random(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_i);
      for (int l = 0; l < WIDTH; l++) begin
        x_model[load_ptr][l] = word_t'($random(seed));
        load_data_i[l] <= x_model[load_ptr][l];
      end
      load_i   <= 1'b1;
      load_ptr = (load_ptr + 1) % ENTRIES; // row first, then slot.
    end
    @(posedge clk_i);
    load_i <= 1'b0;
  endtask

  task automatic wait_busy();
    int n;
    n = 0;
    while (busy_o !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (busy_o !== 1'b1) begin
      errors++;
      $display("timeout: busy_o did not rise after start_i");
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_o !== 1'b1 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (done_o !== 1'b1) begin
      errors++;
      $display("timeout: done_o never came after a compute");
    end
  endtask

  // mode 1 loads while busy, mode 2 starts again while busy.
  task automatic run_compute(input int mode);
    word_t [WIDTH-1:0] w;
    @(posedge clk_i);
    for (int l = 0; l < WIDTH; l++) begin
      w[l] = word_t'($random(seed));
    end
    for (int r = 0; r < ROWS; r++) begin
      exp_res[r] = expected_row(r, w);
    end
    burst_pending = 1'b1;
    w_i     <= w;
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    wait_busy();
    if (mode == 1) begin
      repeat (8) begin
        @(posedge clk_i);
        load_i <= 1'b1;
        for (int l = 0; l < WIDTH; l++) begin
          load_data_i[l] <= word_t'($random(seed));
        end
      end
      @(posedge clk_i);
      load_i <= 1'b0;
    end else if (mode == 2) begin
      @(posedge clk_i);
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
    end
    wait_done();
  endtask

  initial begin
    rst_ni      <= 1'b0;
    clear_i     <= 1'b0;
    load_i      <= 1'b0;
    start_i     <= 1'b0;
    load_data_i <= '0;
    w_i         <= '0;
    clear_model();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    run_compute(0); // empty buffer gives zero rows.
    load_random(ENTRIES);
    run_compute(0);
    run_compute(0); // same X, new weights.
    run_compute(1);
    run_compute(0); // buffer still holds the full load.
    load_random(3); // load address now off zero.
    clear_buffer();
    load_random(6); // rest stays zero.
    run_compute(0);
    run_compute(2);
    repeat (2 * LATENCY) @(posedge clk_i);
    check_value(64'(bursts), 64'(7), "number of result bursts");
    errors += int'(dut.u_chk.fail_count);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
xmac_pkg.sv
x_buffer.sv
x_loader.sv
x_feeder.sv
mac_row.sv
result_drain.sv
xmac_top.sv
xmac_chk.sv
tb_xmac.sv

// ==== Makefile ====
TOP = tb_xmac

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
